/* rpPkg.sv */
/*
 * RP drive shared definitions
 * Register select codes, function codes, drive states, the desired
 * address word layout and the bit positions of ER1 and DS
 */

`default_nettype none

package rpPkg;

   // Register select on the host bus
   typedef logic [2:0] rpAddr_t;

   localparam rpAddr_t ADDR_CS1 = 3'd0;
   localparam rpAddr_t ADDR_DS  = 3'd1;
   localparam rpAddr_t ADDR_ER1 = 3'd2;
   localparam rpAddr_t ADDR_DA  = 3'd3;
   localparam rpAddr_t ADDR_DC  = 3'd4;

   // CS1 function field, bits 5:1
   typedef logic [4:0] rpFunc_t;

   localparam rpFunc_t FN_NOP    = 5'd0;
   localparam rpFunc_t FN_SEEK   = 5'd2;
   localparam rpFunc_t FN_DRVCLR = 5'd4;
   localparam rpFunc_t FN_OFFSET = 5'd6;
   localparam rpFunc_t FN_RETURN = 5'd7;
   localparam rpFunc_t FN_PRESET = 5'd8;
   localparam rpFunc_t FN_PAKACK = 5'd9;

   // Drive states
   typedef enum logic [4:0] {
      ST_IDLE,
      ST_SEEKCHK,
      ST_SEEKDLY,
      ST_OFFSET,
      ST_RETURN,
      ST_ATA,
      ST_CLEAR,
      ST_PRESET,
      ST_PAKACK
   } rpState_t;

   // DA field view, unused bits held at zero
   typedef struct packed {
      logic [1:0] rsvdHi;
      logic [5:0] track;
      logic [1:0] rsvdLo;
      logic [5:0] sector;
   } rpDaFields_t;

   typedef union packed {
      logic [15:0] raw;
      rpDaFields_t f;
   } rpDa_t;

   // Writable DA bits
   localparam logic [15:0] DA_MASK = 16'h3F3F;

   // ER1 bits
   localparam int ER1_ILF = 0;
   localparam int ER1_IAE = 10;

   // DS bits
   localparam int DS_ATA = 15;
   localparam int DS_ERR = 14;
   localparam int DS_PIP = 13;
   localparam int DS_MOL = 12;
   localparam int DS_WRL = 11;
   localparam int DS_LST = 10;
   localparam int DS_PGM = 9;
   localparam int DS_DPR = 8;
   localparam int DS_DRY = 7;
   localparam int DS_VV  = 6;
   localparam int DS_OM  = 0;

endpackage

`default_nettype wire

/* rpDriveIf.sv */
/*
 * RP drive internal bundle
 * Drive state from the FSM, register contents and the
 * attention clear strobe from the register file
 */

`timescale 1ns/1ps
`default_nettype none

interface rpDriveIf;
   import rpPkg::*;

   rpState_t    state;
   rpDa_t       da;
   logic [15:0] dc;
   logic [15:0] er1;
   logic        ataClr;

   modport regs   (output da, output dc, output er1, output ataClr, input state);
   modport ctrl   (output state, input da, input dc);
   modport status (input state, input da, input dc, input er1, input ataClr);

endinterface

`default_nettype wire

/* rpRegFile.sv */
/*
 * RP drive register file
 * Decodes host bus writes into DA, DC and ER1 loads and into the
 * GO and attention clear strobes, collects error pulses in ER1
 * and multiplexes the register read data
 */

`timescale 1ns/1ps
`default_nettype none

module rpRegFile (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           clr,
   input  wire logic           wr,
   input  wire rpPkg::rpAddr_t addr,
   input  wire logic [15:0]    wrData,
   input  wire logic           iaeSet,
   input  wire logic           ilfSet,
   input  wire logic [15:0]    ds,
   output      logic [15:0]    rdData,
   output      logic           go,
   output      rpPkg::rpFunc_t func,
   rpDriveIf.regs              drv
);

   import rpPkg::*;

   rpDa_t       daReg;
   logic [15:0] dcReg;
   logic [15:0] er1Reg;
   rpFunc_t     cs1Func;
   logic [15:0] errBits;

   //////////////////////////////////////////////////////////////////////
   // Write strobes
   //////////////////////////////////////////////////////////////////////

   // Function field straight off the bus
   assign func = wrData[5:1];

   // GO pulse only on a CS1 write with bit 0 set
   assign go = wr && (addr == ADDR_CS1) && wrData[0];

   // Only the attention bit of DS is writable
   assign drv.ataClr = wr && (addr == ADDR_DS) && wrData[DS_ATA];

   // Last function code written, for CS1 readback
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         cs1Func <= FN_NOP;
      else if (clr)
         cs1Func <= FN_NOP;
      else if (wr && (addr == ADDR_CS1))
         cs1Func <= wrData[5:1];
   end

   // Desired address and cylinder, zeroed by PRESET
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         daReg.raw <= '0;
         dcReg     <= '0;
      end
      else if (clr || (drv.state == ST_PRESET))
      begin
         daReg.raw <= '0;
         dcReg     <= '0;
      end
      else if (wr)
      begin
         // Non-field bits of DA never stick
         if (addr == ADDR_DA)
            daReg.raw <= wrData & DA_MASK;
         if (addr == ADDR_DC)
            dcReg <= wrData;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Error register
   //////////////////////////////////////////////////////////////////////

   // Error pulses from the FSM
   always_comb
   begin
      errBits          = '0;
      errBits[ER1_IAE] = iaeSet;
      errBits[ER1_ILF] = ilfSet;
   end

   // Host write replaces the contents, pulses OR in on top
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         er1Reg <= '0;
      else if (clr || (drv.state == ST_CLEAR))
         er1Reg <= '0;
      else if (wr && (addr == ADDR_ER1))
         er1Reg <= wrData | errBits;
      else
         er1Reg <= er1Reg | errBits;
   end

   assign drv.da  = daReg;
   assign drv.dc  = dcReg;
   assign drv.er1 = er1Reg;

   //////////////////////////////////////////////////////////////////////
   // Read multiplexer
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (addr)
         // DRY mirrored from DS, GO always reads 0
         ADDR_CS1: rdData = {8'h00, ds[DS_DRY], 1'b0, cs1Func, 1'b0};
         ADDR_DS:  rdData = ds;
         ADDR_ER1: rdData = er1Reg;
         ADDR_DA:  rdData = daReg.raw;
         ADDR_DC:  rdData = dcReg;
         default:  rdData = '0;
      endcase
   end

endmodule

`default_nettype wire

/* rpDriveCtrl.sv */
/*
 * RP drive state machine
 * Starts functions on GO, validates the seek address against the
 * geometry, times positioning with a down-counter and raises
 * attention when a function completes or is rejected
 */

`timescale 1ns/1ps
`default_nettype none

module rpDriveCtrl #(
   parameter int unsigned LAST_SECTOR = 19,
   parameter int unsigned LAST_TRACK  = 18,
   parameter int unsigned LAST_CYL    = 814,
   parameter int unsigned SEEK_CYCLES = 12
) (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           clr,
   input  wire logic           go,
   input  wire rpPkg::rpFunc_t func,
   output      logic           iaeSet,
   output      logic           ilfSet,
   rpDriveIf.ctrl              drv
);

   import rpPkg::*;

   // Geometry limits at register width
   localparam logic [5:0]  MAX_SECT = 6'(LAST_SECTOR);
   localparam logic [5:0]  MAX_TRK  = 6'(LAST_TRACK);
   localparam logic [15:0] MAX_CYL  = 16'(LAST_CYL);

   // Delay counter sized for the full positioning time
   localparam int               CNT_W    = $clog2(SEEK_CYCLES + 1);
   localparam logic [CNT_W-1:0] DLY_LOAD = CNT_W'(SEEK_CYCLES - 1);

   rpState_t         state;
   rpState_t         stateNext;
   logic [CNT_W-1:0] dlyCnt;
   logic             addrBad;
   logic             funcBad;
   logic             dlyDone;

   //////////////////////////////////////////////////////////////////////
   // Seek address check and function decode
   //////////////////////////////////////////////////////////////////////

   // Any field past the last legal value rejects the seek
   assign addrBad = (drv.da.f.sector > MAX_SECT) ||
                    (drv.da.f.track  > MAX_TRK)  ||
                    (drv.dc          > MAX_CYL);

   always_comb
   begin
      case (func)
         FN_NOP, FN_SEEK, FN_DRVCLR, FN_OFFSET,
         FN_RETURN, FN_PRESET, FN_PAKACK:
            funcBad = 1'b0;
         default:
            funcBad = 1'b1;
      endcase
   end

   // Error pulses, one cycle each
   assign iaeSet = (state == ST_SEEKCHK) && addrBad;
   assign ilfSet = (state == ST_IDLE) && go && funcBad;

   //////////////////////////////////////////////////////////////////////
   // Positioning delay
   //////////////////////////////////////////////////////////////////////

   // Held at load value outside SEEKDLY, counts down inside it
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dlyCnt <= DLY_LOAD;
      else if (clr || (state != ST_SEEKDLY))
         dlyCnt <= DLY_LOAD;
      else if (dlyCnt != '0)
         dlyCnt <= dlyCnt - 1'b1;
   end

   assign dlyDone = (dlyCnt == '0);

   //////////////////////////////////////////////////////////////////////
   // State machine
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      stateNext = state;
      case (state)
         ST_IDLE:
            // GO while busy never reaches here
            if (go)
            begin
               case (func)
                  FN_NOP:    stateNext = ST_IDLE;
                  FN_SEEK:   stateNext = ST_SEEKCHK;
                  FN_DRVCLR: stateNext = ST_CLEAR;
                  FN_OFFSET: stateNext = ST_OFFSET;
                  FN_RETURN: stateNext = ST_RETURN;
                  FN_PRESET: stateNext = ST_PRESET;
                  FN_PAKACK: stateNext = ST_PAKACK;
                  default:   stateNext = ST_ATA;
               endcase
            end
         ST_SEEKCHK:
            stateNext = addrBad ? ST_ATA : ST_SEEKDLY;
         // Offset and return share the positioning path
         ST_OFFSET, ST_RETURN:
            stateNext = ST_SEEKDLY;
         ST_SEEKDLY:
            if (dlyDone)
               stateNext = ST_ATA;
         ST_ATA, ST_CLEAR, ST_PRESET, ST_PAKACK:
            stateNext = ST_IDLE;
         default:
            stateNext = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         state <= ST_IDLE;
      else if (clr)
         state <= ST_IDLE;
      else
         state <= stateNext;
   end

   assign drv.state = state;

endmodule

`default_nettype wire

/* rpStatusReg.sv */
/*
 * RP drive status word
 * Keeps the attention, volume valid and offset mode flags and
 * assembles DS from drive state, registers and media inputs
 */

`timescale 1ns/1ps
`default_nettype none

module rpStatusReg #(
   parameter int unsigned LAST_SECTOR = 19,
   parameter int unsigned LAST_TRACK  = 18,
   parameter int unsigned LAST_CYL    = 814
) (
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic        clr,
   input  wire logic        rpCD,
   input  wire logic        rpWP,
   output      logic [15:0] ds,
   rpDriveIf.status         drv
);

   import rpPkg::*;

   localparam logic [5:0]  MAX_SECT = 6'(LAST_SECTOR);
   localparam logic [5:0]  MAX_TRK  = 6'(LAST_TRACK);
   localparam logic [15:0] MAX_CYL  = 16'(LAST_CYL);

   logic ata;
   logic vv;
   logic om;
   logic lst;

   //////////////////////////////////////////////////////////////////////
   // Status flags
   //////////////////////////////////////////////////////////////////////

   // Attention, set on completion, cleared by host or drive clear
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ata <= 1'b0;
      else if (clr || drv.ataClr || (drv.state == ST_CLEAR))
         ata <= 1'b0;
      else if (drv.state == ST_ATA)
         ata <= 1'b1;
   end

   // Volume valid, lost as soon as the card goes away while idle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         vv <= 1'b0;
      else if (clr)
         vv <= 1'b0;
      else if (drv.state == ST_IDLE)
         vv <= vv & rpCD;
      else if ((drv.state == ST_PRESET) || (drv.state == ST_PAKACK))
         vv <= rpCD;
   end

   // Offset mode
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         om <= 1'b0;
      else if (clr)
         om <= 1'b0;
      else if (drv.state == ST_OFFSET)
         om <= 1'b1;
      else if (drv.state == ST_RETURN)
         om <= 1'b0;
   end

   // Address sits on the very last sector of the pack
   assign lst = (drv.da.f.sector == MAX_SECT) &&
                (drv.da.f.track  == MAX_TRK)  &&
                (drv.dc          == MAX_CYL);

   //////////////////////////////////////////////////////////////////////
   // DS assembly
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      ds         = '0;
      ds[DS_ATA] = ata;
      ds[DS_ERR] = (drv.er1 != '0);
      ds[DS_PIP] = (drv.state == ST_SEEKDLY);
      ds[DS_MOL] = rpCD;
      ds[DS_WRL] = rpWP;
      ds[DS_LST] = lst;
      ds[DS_PGM] = 1'b0;
      ds[DS_DPR] = 1'b1;
      ds[DS_DRY] = (drv.state == ST_IDLE);
      ds[DS_VV]  = vv;
      ds[DS_OM]  = om;
   end

endmodule

`default_nettype wire

/* rpDrive.sv */
/*
 * RP drive top level
 * Register file, drive state machine and status word joined
 * through the drive bundle, with attention out for an interrupt
 */

`timescale 1ns/1ps
`default_nettype none

module rpDrive #(
   parameter int unsigned LAST_SECTOR = 19,
   parameter int unsigned LAST_TRACK  = 18,
   parameter int unsigned LAST_CYL    = 814,
   parameter int unsigned SEEK_CYCLES = 12
) (
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic        clr,
   input  wire logic        wr,
   input  wire logic [2:0]  addr,
   input  wire logic [15:0] wrData,
   input  wire logic        rpCD,
   input  wire logic        rpWP,
   output      logic [15:0] rdData,
   output      logic        attn
);

   import rpPkg::*;

   rpFunc_t     func;
   logic        go;
   logic        iaeSet;
   logic        ilfSet;
   logic [15:0] ds;

   rpDriveIf drvIf ();

   // Host register access
   rpRegFile uRegFile (
      .clk    (clk),
      .rst    (rst),
      .clr    (clr),
      .wr     (wr),
      .addr   (addr),
      .wrData (wrData),
      .iaeSet (iaeSet),
      .ilfSet (ilfSet),
      .ds     (ds),
      .rdData (rdData),
      .go     (go),
      .func   (func),
      .drv    (drvIf)
   );

   // Function sequencing
   rpDriveCtrl #(
      .LAST_SECTOR (LAST_SECTOR),
      .LAST_TRACK  (LAST_TRACK),
      .LAST_CYL    (LAST_CYL),
      .SEEK_CYCLES (SEEK_CYCLES)
   ) uDriveCtrl (
      .clk    (clk),
      .rst    (rst),
      .clr    (clr),
      .go     (go),
      .func   (func),
      .iaeSet (iaeSet),
      .ilfSet (ilfSet),
      .drv    (drvIf)
   );

   rpStatusReg #(
      .LAST_SECTOR (LAST_SECTOR),
      .LAST_TRACK  (LAST_TRACK),
      .LAST_CYL    (LAST_CYL)
   ) uStatusReg (
      .clk  (clk),
      .rst  (rst),
      .clr  (clr),
      .rpCD (rpCD),
      .rpWP (rpWP),
      .ds   (ds),
      .drv  (drvIf)
   );

   // Interrupt request follows DS attention
   assign attn = ds[DS_ATA];

endmodule

`default_nettype wire

/* tbRpDrive.sv */
/*
 * RP drive testbench
 * Builds a table of bus writes, read checks, ready waits and clear
 * pulses, applies it on falling edges and compares the read data
 * and the attention line against values built from the drive rules
 */

`timescale 1ns/1ps
`default_nettype none

module tbRpDrive;

   // Table operations
   localparam logic [1:0] OP_WR   = 2'd0;
   localparam logic [1:0] OP_RD   = 2'd1;
   localparam logic [1:0] OP_WAIT = 2'd2;
   localparam logic [1:0] OP_CLR  = 2'd3;

   // Register selects
   localparam logic [2:0] REG_CS1 = 3'd0;
   localparam logic [2:0] REG_DS  = 3'd1;
   localparam logic [2:0] REG_ER1 = 3'd2;
   localparam logic [2:0] REG_DA  = 3'd3;
   localparam logic [2:0] REG_DC  = 3'd4;

   // Function codes
   localparam logic [4:0] FUNC_UNDEF  = 5'd1;
   localparam logic [4:0] FUNC_SEEK   = 5'd2;
   localparam logic [4:0] FUNC_DRVCLR = 5'd4;
   localparam logic [4:0] FUNC_OFFSET = 5'd6;
   localparam logic [4:0] FUNC_RETURN = 5'd7;
   localparam logic [4:0] FUNC_PRESET = 5'd8;
   localparam logic [4:0] FUNC_PAKACK = 5'd9;

   // Default geometry of the DUT
   localparam logic [5:0]  LAST_SECT     = 6'd19;
   localparam logic [5:0]  LAST_TRK      = 6'd18;
   localparam logic [15:0] LAST_CYLINDER = 16'd814;

   localparam int READY_LIMIT = 100;

   typedef struct packed {
      logic [1:0]  op;
      logic [2:0]  addr;
      logic [15:0] data;
      logic        cd;
      logic        wp;
      logic [15:0] expVal;
   } stepEntry_t;

   logic        clk;
   logic        rst;
   logic        clr;
   logic        wr;
   logic [2:0]  addr;
   logic [15:0] wrData;
   logic        rpCD;
   logic        rpWP;
   logic [15:0] rdData;
   logic        attn;

   stepEntry_t  steps[$];
   logic [31:0] lfsr;
   logic        buildWp;
   int          checks;
   int          valueErrors;
   int          timeouts;

   rpDrive u_dut (
      .clk    (clk),
      .rst    (rst),
      .clr    (clr),
      .wr     (wr),
      .addr   (addr),
      .wrData (wrData),
      .rpCD   (rpCD),
      .rpWP   (rpWP),
      .rdData (rdData),
      .attn   (attn)
   );

   // 8 ns clock
   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Expected value helpers
   //////////////////////////////////////////////////////////////////////

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit
   task automatic randWord(output logic [15:0] w);
      int b;
      w = '0;
      for (b = 0; b < 16; b++)
      begin
         lfsr = lfsrNext(lfsr);
         w    = {w[14:0], lfsr[0]};
      end
   endtask

   // Flag order ATA ERR PIP MOL WRL LST DRY VV OM, PGM 0 and DPR 1
   function automatic logic [15:0] dsWord(input logic [8:0] f);
      return {f[8:3], 1'b0, 1'b1, f[2], f[1], 5'b00000, f[0]};
   endfunction

   // CS1 readback, function in 5:1 and DRY in bit 7
   function automatic logic [15:0] cs1Word(input logic dry, input logic [4:0] fn);
      return {8'h00, dry, 1'b0, fn, 1'b0};
   endfunction

   // CS1 write with GO set
   function automatic logic [15:0] goWord(input logic [4:0] fn);
      return {10'b0, fn, 1'b1};
   endfunction

   // DA layout, track 13:8 and sector 5:0
   function automatic logic [15:0] daWord(input logic [5:0] trk, input logic [5:0] sect);
      return {2'b00, trk, 2'b00, sect};
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Table construction
   //////////////////////////////////////////////////////////////////////

   task automatic appendEntry(input logic [1:0] op, input logic [2:0] a,
                              input logic [15:0] d, input logic cd,
                              input logic [15:0] e);
      stepEntry_t ent;
      ent.op     = op;
      ent.addr   = a;
      ent.data   = d;
      ent.cd     = cd;
      ent.wp     = buildWp;
      ent.expVal = e;
      steps.push_back(ent);
   endtask

   task automatic writeReg(input logic [2:0] a, input logic [15:0] d, input logic cd);
      appendEntry(OP_WR, a, d, cd, 16'h0000);
   endtask

   task automatic expectReg(input logic [2:0] a, input logic [15:0] e, input logic cd);
      appendEntry(OP_RD, a, 16'h0000, cd, e);
   endtask

   task automatic awaitReady(input logic cd);
      appendEntry(OP_WAIT, REG_DS, 16'h0000, cd, 16'h0000);
   endtask

   task automatic pulseClear(input logic cd);
      appendEntry(OP_CLR, REG_DS, 16'h0000, cd, 16'h0000);
   endtask

   task automatic buildTable();
      logic [15:0] rDa;
      logic [15:0] rDc;
      int          k;
      // Idle status after reset, MOL and WRL follow the inputs
      buildWp = 1'b1;
      expectReg(REG_DS, dsWord(9'b000110100), 1'b1);
      buildWp = 1'b0;
      expectReg(REG_DS, dsWord(9'b000000100), 1'b0);
      expectReg(REG_ER1, 16'h0000, 1'b1);
      expectReg(REG_DA, 16'h0000, 1'b1);
      expectReg(REG_DC, 16'h0000, 1'b1);
      expectReg(REG_CS1, cs1Word(1'b1, 5'd0), 1'b1);
      // Random round trip, DA keeps only its fields
      for (k = 0; k < 4; k++)
      begin
         randWord(rDa);
         randWord(rDc);
         writeReg(REG_DA, rDa, 1'b1);
         writeReg(REG_DC, rDc, 1'b1);
         expectReg(REG_DA, daWord(rDa[13:8], rDa[5:0]), 1'b1);
         expectReg(REG_DC, rDc, 1'b1);
      end
      // Valid seek, SEEKCHK then PIP during positioning
      writeReg(REG_DA, daWord(6'd5, 6'd7), 1'b1);
      writeReg(REG_DC, 16'd100, 1'b1);
      writeReg(REG_CS1, goWord(FUNC_SEEK), 1'b1);
      expectReg(REG_DS, dsWord(9'b000100000), 1'b1);
      expectReg(REG_DS, dsWord(9'b001100000), 1'b1);
      expectReg(REG_CS1, cs1Word(1'b0, FUNC_SEEK), 1'b1);
      awaitReady(1'b1);
      expectReg(REG_DS, dsWord(9'b100100100), 1'b1);
      writeReg(REG_DS, 16'h8000, 1'b1);
      expectReg(REG_DS, dsWord(9'b000100100), 1'b1);
      // Sector past the last one is rejected
      writeReg(REG_DA, daWord(6'd0, LAST_SECT + 6'd1), 1'b1);
      writeReg(REG_CS1, goWord(FUNC_SEEK), 1'b1);
      awaitReady(1'b1);
      expectReg(REG_ER1, 16'h0400, 1'b1);
      expectReg(REG_DS, dsWord(9'b110100100), 1'b1);
      writeReg(REG_CS1, goWord(FUNC_DRVCLR), 1'b1);
      awaitReady(1'b1);
      expectReg(REG_ER1, 16'h0000, 1'b1);
      expectReg(REG_DS, dsWord(9'b000100100), 1'b1);
      // Unknown function code
      writeReg(REG_CS1, goWord(FUNC_UNDEF), 1'b1);
      awaitReady(1'b1);
      expectReg(REG_ER1, 16'h0001, 1'b1);
      expectReg(REG_DS, dsWord(9'b110100100), 1'b1);
      writeReg(REG_ER1, 16'h0000, 1'b1);
      writeReg(REG_DS, 16'h8000, 1'b1);
      expectReg(REG_DS, dsWord(9'b000100100), 1'b1);
      // LST, then one field off at a time
      writeReg(REG_DA, daWord(LAST_TRK, LAST_SECT), 1'b1);
      writeReg(REG_DC, LAST_CYLINDER, 1'b1);
      expectReg(REG_DS, dsWord(9'b000101100), 1'b1);
      writeReg(REG_DC, LAST_CYLINDER - 16'd1, 1'b1);
      expectReg(REG_DS, dsWord(9'b000100100), 1'b1);
      writeReg(REG_DC, LAST_CYLINDER, 1'b1);
      expectReg(REG_DS, dsWord(9'b000101100), 1'b1);
      writeReg(REG_DA, daWord(LAST_TRK, LAST_SECT - 6'd1), 1'b1);
      expectReg(REG_DS, dsWord(9'b000100100), 1'b1);
      writeReg(REG_DA, daWord(LAST_TRK - 6'd1, LAST_SECT), 1'b1);
      expectReg(REG_DS, dsWord(9'b000100100), 1'b1);
      writeReg(REG_DA, daWord(LAST_TRK, LAST_SECT), 1'b1);
      expectReg(REG_DS, dsWord(9'b000101100), 1'b1);
      // Preset sets VV and zeroes DA and DC
      writeReg(REG_CS1, goWord(FUNC_PRESET), 1'b1);
      awaitReady(1'b1);
      expectReg(REG_DS, dsWord(9'b000100110), 1'b1);
      expectReg(REG_DA, 16'h0000, 1'b1);
      expectReg(REG_DC, 16'h0000, 1'b1);
      // Card removed while idle
      expectReg(REG_ER1, 16'h0000, 1'b0);
      expectReg(REG_DS, dsWord(9'b000000100), 1'b0);
      writeReg(REG_CS1, goWord(FUNC_PAKACK), 1'b1);
      awaitReady(1'b1);
      expectReg(REG_DS, dsWord(9'b000100110), 1'b1);
      // Offset mode on and off
      writeReg(REG_CS1, goWord(FUNC_OFFSET), 1'b1);
      awaitReady(1'b1);
      expectReg(REG_DS, dsWord(9'b100100111), 1'b1);
      writeReg(REG_DS, 16'h8000, 1'b1);
      writeReg(REG_CS1, goWord(FUNC_RETURN), 1'b1);
      awaitReady(1'b1);
      expectReg(REG_DS, dsWord(9'b100100110), 1'b1);
      writeReg(REG_DS, 16'h8000, 1'b1);
      // Every flag up, then clr in the middle of a seek
      writeReg(REG_DA, daWord(6'd1, 6'd1), 1'b1);
      writeReg(REG_DC, 16'd5, 1'b1);
      writeReg(REG_CS1, goWord(FUNC_OFFSET), 1'b1);
      awaitReady(1'b1);
      writeReg(REG_ER1, 16'h0400, 1'b1);
      writeReg(REG_CS1, goWord(FUNC_SEEK), 1'b1);
      expectReg(REG_DS, dsWord(9'b110100011), 1'b1);
      pulseClear(1'b1);
      expectReg(REG_DS, dsWord(9'b000100100), 1'b1);
      expectReg(REG_ER1, 16'h0000, 1'b1);
      expectReg(REG_DA, 16'h0000, 1'b1);
      expectReg(REG_DC, 16'h0000, 1'b1);
      expectReg(REG_CS1, cs1Word(1'b1, 5'd0), 1'b1);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   task automatic compareRead(input int idx, input logic [2:0] a, input logic [15:0] e);
      checks++;
      assert (rdData === e)
      else
      begin
         valueErrors++;
         $display("Error at %0t ns: rdData (step %0d, addr %0d) expected 16'h%04h, got 16'h%04h",
                  $time, idx, a, e, rdData);
      end
      // Interrupt line mirrors DS ATA
      if (a == REG_DS)
      begin
         checks++;
         assert (attn === e[15])
         else
         begin
            valueErrors++;
            $display("Error at %0t ns: attn (step %0d) expected %b, got %b",
                     $time, idx, e[15], attn);
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Table player
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      stepEntry_t s;
      int         i;
      int         n;
      logic       ready;
      rst         = 1'b1;
      clr         = 1'b0;
      wr          = 1'b0;
      addr        = 3'd0;
      wrData      = 16'h0000;
      rpCD        = 1'b1;
      rpWP        = 1'b0;
      checks      = 0;
      valueErrors = 0;
      timeouts    = 0;
      lfsr        = 32'h5845;
      buildWp     = 1'b0;
      buildTable();
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (i = 0; i < steps.size(); i++)
      begin
         s = steps[i];
         // One table entry per falling edge
         @(negedge clk);
         wr     = 1'b0;
         clr    = 1'b0;
         rpCD   = s.cd;
         rpWP   = s.wp;
         addr   = s.addr;
         wrData = s.data;
         case (s.op)
            OP_WR:  wr = 1'b1;
            OP_CLR: clr = 1'b1;
            OP_RD:
            begin
               #2;
               compareRead(i, s.addr, s.expVal);
            end
            default:
            begin
               // Poll DRY, bounded
               n     = 0;
               ready = 1'b0;
               #2;
               while (!ready && (n < READY_LIMIT))
               begin
                  if (rdData[7] === 1'b1)
                     ready = 1'b1;
                  else
                  begin
                     @(negedge clk);
                     n++;
                     #2;
                  end
               end
               checks++;
               assert (ready)
               else
               begin
                  timeouts++;
                  $display("Timeout: DS DRY did not return within %0d cycles at step %0d",
                           READY_LIMIT, i);
               end
            end
         endcase
      end
      @(negedge clk);
      wr  = 1'b0;
      clr = 1'b0;
      $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, valueErrors, timeouts);
      if ((valueErrors == 0) && (timeouts == 0))
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
rpPkg.sv
rpDriveIf.sv
rpRegFile.sv
rpDriveCtrl.sv
rpStatusReg.sv
rpDrive.sv
tbRpDrive.sv

/* sim.sh */
#!/bin/sh
# Builds the RP drive testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tbRpDrive -f filelist.f -o simRpDrive
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/simRpDrive > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "Simulation run exited with status $status"
   exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
   echo "Result: PASS"
   exit 0
fi

echo "Result: FAIL"
exit 1
